// File: common/lcdPkg.sv
`default_nettype none

package lcdPkg;

	// unsigned screen coordinate, wide enough for 320 plus a sprite
	typedef logic [10:0] coordT;

	// signed per-frame velocity
	typedef logic signed [10:0] velocityT;

	// frame step index, command steps then pixel steps
	typedef logic [17:0] stepT;

	// one word on the 8080 data bus
	typedef logic [15:0] lcdWordT;

	// panel geometry, portrait 240x320
	localparam coordT screenWidth = 11'd240;
	localparam coordT screenHeight = 11'd320;
	localparam stepT pixelCount = 18'd76800;

	// cursor-home sequence length, then every pixel once
	localparam stepT cmdSteps = 18'd7;
	localparam stepT frameSteps = cmdSteps + pixelCount;

	// both sprites are square
	localparam coordT spriteSize = 11'd20;

	// character origin after reset or after running off the low edge
	localparam coordT charStart = 11'd10;

	// panel command words, sent with RS low
	localparam lcdWordT cmdColumnAddr = 16'h002a;
	localparam lcdWordT cmdPageAddr = 16'h002b;
	localparam lcdWordT cmdMemWrite = 16'h002c;

	// RGB565 palette of the coin game
	localparam lcdWordT colorBoth = 16'h0000;
	localparam lcdWordT colorChar = 16'hf0ff;
	localparam lcdWordT colorCoin = 16'h00aa;
	localparam lcdWordT colorBlank = 16'hffff;

endpackage

`default_nettype wire

// File: common/scanStepIf.sv
`timescale 1ns/1ps
`default_nettype none

// one scan step per cycle, from the sequencer to the renderer
interface scanStepIf;

	// pixel being scanned, only meaningful during pixel steps
	lcdPkg::coordT posX;
	lcdPkg::coordT posY;
	logic pixelActive;

	// cursor-home word and its RS level, valid during command steps
	lcdPkg::lcdWordT cmdWord;
	logic cmdRs;

	// low on the strobe cycle of each word
	logic writePhase;
	logic frameStart;

	modport source (output posX, posY, pixelActive, cmdWord, cmdRs, writePhase, frameStart);
	modport sink (input posX, posY, pixelActive, cmdWord, cmdRs, writePhase, frameStart);

endinterface

`default_nettype wire

// File: common/lcdWriteIf.sv
`timescale 1ns/1ps
`default_nettype none

// one 8080 bus write as the engine presents it
interface lcdWriteIf;

	lcdPkg::lcdWordT data;
	logic rs;
	// strobes are active low, panel latches on the rising edge of wrN
	logic wrN;
	logic csN;

	modport source (output data, rs, wrN, csN);
	modport sink (input data, rs, wrN, csN);

endinterface

`default_nettype wire

// File: frameWriter/frameSequencer.sv
`timescale 1ns/1ps
`default_nettype none

module frameSequencer (
	input wire logic clk,
	input wire logic rst,
	input wire logic engineOwns,
	scanStepIf.source scan
);

	lcdPkg::stepT step;
	logic writePhase;
	lcdPkg::coordT posX;
	lcdPkg::coordT posY;
	logic lastStep;
	logic rowEnd;

	assign lastStep = (step == lcdPkg::frameSteps - 18'd1);
	assign rowEnd = (posX == lcdPkg::screenWidth - 11'd1);

	// two cycles per word: strobe low, then strobe high
	// held at step 0 while the CPU owns the panel
	always_ff @(posedge clk)
	begin
		if (rst || !engineOwns)
		begin
			step <= '0;
			writePhase <= 1'b0;
		end
		else
		begin
			writePhase <= !writePhase;
			// step moves on after the high half of the word
			if (writePhase)
			begin
				if (lastStep)
					step <= '0;
				else
					step <= step + 18'd1;
			end
		end
	end

	// pixel scan, row by row from the top left corner
	always_ff @(posedge clk)
	begin
		if (rst || !engineOwns)
		begin
			posX <= '0;
			posY <= '0;
		end
		else if (writePhase && scan.pixelActive)
		begin
			if (lastStep)
			begin
				// last pixel written, next frame starts from the origin
				posX <= '0;
				posY <= '0;
			end
			else if (rowEnd)
			begin
				posX <= '0;
				posY <= posY + 11'd1;
			end
			else
			begin
				posX <= posX + 11'd1;
			end
		end
	end

	// cursor-home sequence, equivalent of setting the cursor to (0,0)
	// steps 1,2,4,5 are the zero start coordinates with RS high
	always_comb
	begin
		scan.cmdWord = 16'h0000;
		scan.cmdRs = 1'b1;
		case (step)
			18'd0:
			begin
				scan.cmdWord = lcdPkg::cmdColumnAddr;
				scan.cmdRs = 1'b0;
			end
			18'd3:
			begin
				scan.cmdWord = lcdPkg::cmdPageAddr;
				scan.cmdRs = 1'b0;
			end
			18'd6:
			begin
				scan.cmdWord = lcdPkg::cmdMemWrite;
				scan.cmdRs = 1'b0;
			end
			default:
			begin
				scan.cmdWord = 16'h0000;
				scan.cmdRs = 1'b1;
			end
		endcase
	end

	assign scan.posX = posX;
	assign scan.posY = posY;
	assign scan.pixelActive = (step >= lcdPkg::cmdSteps);
	assign scan.writePhase = writePhase;
	// only a real frame start when the engine drives the panel
	assign scan.frameStart = engineOwns && (step == '0);

	// the row counter never runs past the panel during a scan
	posYInRange: assert property (@(posedge clk) disable iff (rst)
		scan.pixelActive |-> (posY < lcdPkg::screenHeight))
		else $error("scan row %0d outside the panel", posY);

endmodule

`default_nettype wire

// File: frameWriter/spriteRenderer.sv
`timescale 1ns/1ps
`default_nettype none

module spriteRenderer (
	input wire logic clk,
	input wire logic rst,
	input wire logic engineOwns,
	scanStepIf.sink scan,
	input wire lcdPkg::coordT charX,
	input wire lcdPkg::coordT charY,
	input wire lcdPkg::coordT coinX,
	input wire lcdPkg::coordT coinY,
	lcdWriteIf.source lcdBus,
	output logic finish
);

	logic charCover;
	logic coinCover;
	logic hit;
	lcdPkg::lcdWordT pixelColor;
	lcdPkg::lcdWordT dataQ;
	logic rsQ;
	logic wrNQ;
	logic csNQ;

	// sprite covers origin .. origin+spriteSize-1 on one axis
	// far edge is computed one bit wider so a large origin cannot wrap
	function automatic logic covers(input lcdPkg::coordT pixel, input lcdPkg::coordT origin);
		logic [11:0] farEdge;
		farEdge = {1'b0, origin} + {1'b0, lcdPkg::spriteSize};
		return (pixel >= origin) && ({1'b0, pixel} < farEdge);
	endfunction

	assign charCover = covers(scan.posX, charX) && covers(scan.posY, charY);
	assign coinCover = covers(scan.posX, coinX) && covers(scan.posY, coinY);

	// four fixed colors by coverage
	always_comb
	begin
		case ({charCover, coinCover})
			2'b11: pixelColor = lcdPkg::colorBoth;
			2'b10: pixelColor = lcdPkg::colorChar;
			2'b01: pixelColor = lcdPkg::colorCoin;
			default: pixelColor = lcdPkg::colorBlank;
		endcase
	end

	// outgoing word, one cycle behind the scan step
	always_ff @(posedge clk)
	begin
		if (scan.pixelActive)
		begin
			dataQ <= pixelColor;
			rsQ <= 1'b1;
		end
		else
		begin
			dataQ <= scan.cmdWord;
			rsQ <= scan.cmdRs;
		end
	end

	// strobes idle high until the engine owns the panel
	always_ff @(posedge clk)
	begin
		if (rst || !engineOwns)
		begin
			wrNQ <= 1'b1;
			csNQ <= 1'b1;
		end
		else
		begin
			wrNQ <= scan.writePhase;
			csNQ <= scan.writePhase;
		end
	end

	// collision seen on the registered pixel, then latched into finish
	// released only when the CPU takes the panel back
	always_ff @(posedge clk)
	begin
		if (rst || !engineOwns)
		begin
			hit <= 1'b0;
			finish <= 1'b0;
		end
		else
		begin
			hit <= scan.pixelActive && charCover && coinCover;
			if (hit)
				finish <= 1'b1;
		end
	end

	assign lcdBus.data = dataQ;
	assign lcdBus.rs = rsQ;
	assign lcdBus.wrN = wrNQ;
	assign lcdBus.csN = csNQ;

endmodule

`default_nettype wire

// File: game/spriteMotion.sv
`timescale 1ns/1ps
`default_nettype none

module spriteMotion (
	input wire logic clk,
	input wire logic rst,
	input wire logic engineOwns,
	input wire logic frameStart,
	input wire lcdPkg::velocityT charVx,
	input wire lcdPkg::velocityT charVy,
	input wire lcdPkg::coordT coinX0,
	input wire lcdPkg::coordT coinY0,
	input wire lcdPkg::velocityT coinVx,
	input wire lcdPkg::velocityT coinVy,
	output lcdPkg::coordT charX,
	output lcdPkg::coordT charY,
	output lcdPkg::coordT coinX,
	output lcdPkg::coordT coinY
);

	logic frameStartQ;
	logic update;

	// position plus signed velocity, 13 bits so the sign survives
	function automatic logic signed [12:0] stepAxis(input lcdPkg::coordT pos,
		input lcdPkg::velocityT vel);
		logic signed [12:0] posWide;
		logic signed [12:0] velWide;
		posWide = $signed({2'b00, pos});
		velWide = $signed({{2{vel[10]}}, vel});
		return posWide + velWide;
	endfunction

	// character stops at the edges, back to its start if it goes negative
	function automatic lcdPkg::coordT clampAxis(input lcdPkg::coordT pos,
		input lcdPkg::velocityT vel, input lcdPkg::coordT limit);
		logic signed [12:0] sum;
		sum = stepAxis(pos, vel);
		if (sum < 0)
			return lcdPkg::charStart;
		else if (sum >= $signed({2'b00, limit}))
			return limit;
		else
			return sum[10:0];
	endfunction

	// coin leaves one edge and comes back in from the other
	function automatic lcdPkg::coordT wrapAxis(input lcdPkg::coordT pos,
		input lcdPkg::velocityT vel, input lcdPkg::coordT limit);
		logic signed [12:0] sum;
		sum = stepAxis(pos, vel);
		if (sum < 1)
			return limit;
		else if (sum >= $signed({2'b00, limit}))
			return lcdPkg::spriteSize + 11'd1;
		else
			return sum[10:0];
	endfunction

	// move once, on the first cycle of step 0, before any pixel is scanned
	always_ff @(posedge clk)
	begin
		if (rst)
			frameStartQ <= 1'b0;
		else
			frameStartQ <= frameStart;
	end

	assign update = frameStart && !frameStartQ;

	// limit per axis is the highest origin that keeps a sprite fully on the panel
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			charX <= lcdPkg::charStart;
			charY <= lcdPkg::charStart;
		end
		else if (update)
		begin
			charX <= clampAxis(charX, charVx, lcdPkg::screenWidth - lcdPkg::spriteSize);
			charY <= clampAxis(charY, charVy, lcdPkg::screenHeight - lcdPkg::spriteSize);
		end
	end

	// coin start point comes from the CPU while it owns the panel
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			coinX <= lcdPkg::screenWidth - lcdPkg::spriteSize;
			coinY <= lcdPkg::screenHeight - lcdPkg::spriteSize;
		end
		else if (!engineOwns)
		begin
			coinX <= coinX0;
			coinY <= coinY0;
		end
		else if (update)
		begin
			coinX <= wrapAxis(coinX, coinVx, lcdPkg::screenWidth - lcdPkg::spriteSize);
			coinY <= wrapAxis(coinY, coinVy, lcdPkg::screenHeight - lcdPkg::spriteSize);
		end
	end

	// character stays fully visible whatever the velocity
	charXInRange: assert property (@(posedge clk) disable iff (rst)
		charX <= lcdPkg::screenWidth - lcdPkg::spriteSize)
		else $error("character x %0d beyond the right edge", charX);

endmodule

`default_nettype wire

// File: src/busArbiter.sv
`timescale 1ns/1ps
`default_nettype none

module busArbiter (
	input wire logic clk,
	input wire logic rst,
	input wire lcdPkg::lcdWordT cpuD,
	input wire logic cpuRs,
	input wire logic cpuWrN,
	input wire logic cpuRdN,
	input wire logic cpuCsN,
	input wire logic cpuResetN,
	input wire logic bufferRequest,
	lcdWriteIf.sink engineBus,
	output logic engineOwns,
	output lcdPkg::lcdWordT screenD,
	output logic screenRs,
	output logic screenWrN,
	output logic screenRdN,
	output logic screenCsN,
	output logic screenResetN
);

	logic memWriteCmd;

	// CPU memory-write command, seen on the bus as it is written
	assign memWriteCmd = (cpuD == lcdPkg::cmdMemWrite) && !cpuRs && !cpuCsN;

	// bufferRequest picks the owner at the command edge
	// CPU owns the panel out of reset
	always_ff @(posedge clk)
	begin
		if (rst)
			engineOwns <= 1'b0;
		else if (memWriteCmd)
			engineOwns <= bufferRequest;
	end

	// screen bus mux, combinational so CPU writes pass in the same cycle
	assign screenD = engineOwns ? engineBus.data : cpuD;
	assign screenRs = engineOwns ? engineBus.rs : cpuRs;
	assign screenWrN = engineOwns ? engineBus.wrN : cpuWrN;
	assign screenCsN = engineOwns ? engineBus.csN : cpuCsN;

	// engine never reads the panel
	assign screenRdN = engineOwns ? 1'b1 : cpuRdN;

	// panel reset always belongs to the CPU
	assign screenResetN = cpuResetN;

	rdIdleWhileEngine: assert property (@(posedge clk) disable iff (rst)
		engineOwns |-> screenRdN)
		else $error("read strobe active while the engine owns the panel");

endmodule

`default_nettype wire

// File: src/lcdFrameEngine.sv
`timescale 1ns/1ps
`default_nettype none

module lcdFrameEngine (
	input wire logic clk,
	input wire logic rst,
	input wire lcdPkg::lcdWordT cpuD,
	input wire logic cpuRs,
	input wire logic cpuWrN,
	input wire logic cpuRdN,
	input wire logic cpuCsN,
	input wire logic cpuResetN,
	input wire logic bufferRequest,
	input wire lcdPkg::velocityT charVx,
	input wire lcdPkg::velocityT charVy,
	input wire lcdPkg::coordT coinX0,
	input wire lcdPkg::coordT coinY0,
	input wire lcdPkg::velocityT coinVx,
	input wire lcdPkg::velocityT coinVy,
	output lcdPkg::lcdWordT screenD,
	output logic screenRs,
	output logic screenWrN,
	output logic screenRdN,
	output logic screenCsN,
	output logic screenResetN,
	output logic finish,
	output lcdPkg::coordT charX,
	output lcdPkg::coordT charY
);

	logic engineOwns;
	logic frameStart;
	lcdPkg::coordT coinX;
	lcdPkg::coordT coinY;

	scanStepIf scanStep ();
	lcdWriteIf engineBus ();

	// motion only needs the frame start out of the scan step
	assign frameStart = scanStep.frameStart;

	busArbiter i_busArbiter (
		.clk(clk),
		.rst(rst),
		.cpuD(cpuD),
		.cpuRs(cpuRs),
		.cpuWrN(cpuWrN),
		.cpuRdN(cpuRdN),
		.cpuCsN(cpuCsN),
		.cpuResetN(cpuResetN),
		.bufferRequest(bufferRequest),
		.engineBus(engineBus.sink),
		.engineOwns(engineOwns),
		.screenD(screenD),
		.screenRs(screenRs),
		.screenWrN(screenWrN),
		.screenRdN(screenRdN),
		.screenCsN(screenCsN),
		.screenResetN(screenResetN)
	);

	frameSequencer i_frameSequencer (
		.clk(clk),
		.rst(rst),
		.engineOwns(engineOwns),
		.scan(scanStep.source)
	);

	spriteMotion i_spriteMotion (
		.clk(clk),
		.rst(rst),
		.engineOwns(engineOwns),
		.frameStart(frameStart),
		.charVx(charVx),
		.charVy(charVy),
		.coinX0(coinX0),
		.coinY0(coinY0),
		.coinVx(coinVx),
		.coinVy(coinVy),
		.charX(charX),
		.charY(charY),
		.coinX(coinX),
		.coinY(coinY)
	);

	spriteRenderer i_spriteRenderer (
		.clk(clk),
		.rst(rst),
		.engineOwns(engineOwns),
		.scan(scanStep.sink),
		.charX(charX),
		.charY(charY),
		.coinX(coinX),
		.coinY(coinY),
		.lcdBus(engineBus.source),
		.finish(finish)
	);

endmodule

`default_nettype wire

// File: dv/lcdFrameEngineTb.sv
`timescale 1ns/1ps
`default_nettype none

module lcdFrameEngineTb;

	// two cycles per word, seven cursor-home words then every pixel
	localparam int frameCycles = 153614;
	localparam int framePixels = 76800;
	localparam int homeWords = 7;
	localparam int spriteSide = 20;
	localparam int panelWidth = 240;
	localparam int panelHeight = 320;
	localparam int limitX = panelWidth - spriteSide;
	localparam int limitY = panelHeight - spriteSide;
	localparam int maxVectors = 16;

	logic clk;
	logic rst;
	lcdPkg::lcdWordT cpuD;
	logic cpuRs;
	logic cpuWrN;
	logic cpuRdN;
	logic cpuCsN;
	logic cpuResetN;
	logic bufferRequest;
	lcdPkg::velocityT charVx;
	lcdPkg::velocityT charVy;
	lcdPkg::coordT coinX0;
	lcdPkg::coordT coinY0;
	lcdPkg::velocityT coinVx;
	lcdPkg::velocityT coinVy;
	lcdPkg::lcdWordT screenD;
	logic screenRs;
	logic screenWrN;
	logic screenRdN;
	logic screenCsN;
	logic screenResetN;
	logic finish;
	lcdPkg::coordT charX;
	lcdPkg::coordT charY;

	// scenario table, one row per vector line
	int vecCoinX0 [maxVectors];
	int vecCoinY0 [maxVectors];
	int vecCoinVx [maxVectors];
	int vecCoinVy [maxVectors];
	int vecCharVx [maxVectors];
	int vecCharVy [maxVectors];
	int vecFrames [maxVectors];
	int vecFinish [maxVectors];
	int vecCount;
	int curVec;

	int errorCount = 0;
	int testsRun = 0;
	int testsFailed = 0;
	logic [31:0] rngState = 32'hf2c2;
	longint cycleCount = 0;
	longint timeoutLimit = 10000;

	// monitor state and reference model of the game
	logic monitorOn = 1'b0;
	logic lastWrN = 1'b1;
	int wordIndex = 0;
	int frameCount = 0;
	int modelCharX = 10;
	int modelCharY = 10;
	int modelCoinX;
	int modelCoinY;
	int bothSeen;
	int charSeen;
	int coinSeen;
	int blankSeen;

	lcdFrameEngine i_dut (
		.clk(clk),
		.rst(rst),
		.cpuD(cpuD),
		.cpuRs(cpuRs),
		.cpuWrN(cpuWrN),
		.cpuRdN(cpuRdN),
		.cpuCsN(cpuCsN),
		.cpuResetN(cpuResetN),
		.bufferRequest(bufferRequest),
		.charVx(charVx),
		.charVy(charVy),
		.coinX0(coinX0),
		.coinY0(coinY0),
		.coinVx(coinVx),
		.coinVy(coinVy),
		.screenD(screenD),
		.screenRs(screenRs),
		.screenWrN(screenWrN),
		.screenRdN(screenRdN),
		.screenCsN(screenCsN),
		.screenResetN(screenResetN),
		.finish(finish),
		.charX(charX),
		.charY(charY)
	);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// character axis stops at the far edge, restarts at 10 below zero
	function automatic int clampStep(input int pos, input int vel, input int limit);
		int sum;
		sum = pos + vel;
		if (sum < 0)
			return 10;
		else if (sum >= limit)
			return limit;
		return sum;
	endfunction

	// coin axis reenters from the opposite edge
	function automatic int wrapStep(input int pos, input int vel, input int limit);
		int sum;
		sum = pos + vel;
		if (sum < 1)
			return limit;
		else if (sum >= limit)
			return spriteSide + 1;
		return sum;
	endfunction

	// shared length of two sprite spans on one axis, cut to the panel
	function automatic int overlapLen(input int a, input int b, input int extent);
		int lo;
		int hi;
		lo = (a > b) ? a : b;
		if (lo < 0)
			lo = 0;
		hi = ((a < b) ? a : b) + spriteSide;
		if (hi > extent)
			hi = extent;
		return (hi > lo) ? hi - lo : 0;
	endfunction

	function automatic lcdPkg::lcdWordT homeWord(input int idx);
		case (idx)
			0: return 16'h002a;
			3: return 16'h002b;
			6: return 16'h002c;
			default: return 16'h0000;
		endcase
	endfunction

	task automatic driveIdle();
		cpuD = 16'h0000;
		cpuRs = 1'b1;
		cpuWrN = 1'b1;
		cpuRdN = 1'b1;
		cpuCsN = 1'b1;
		cpuResetN = 1'b1;
	endtask

	// memory-write command from the CPU, request level picks the owner
	task automatic writeCommand(input logic request);
		@(negedge clk);
		bufferRequest = request;
		cpuD = lcdPkg::cmdMemWrite;
		cpuRs = 1'b0;
		cpuCsN = 1'b0;
		cpuWrN = 1'b0;
		@(negedge clk);
		driveIdle();
		bufferRequest = 1'b0;
	endtask

	task automatic checkPassthrough(input int count);
		logic [31:0] r;
		for (int i = 0; i < count; i++)
		begin
			@(negedge clk);
			rngState = xorshift(rngState);
			r = rngState;
			cpuD = r[15:0];
			cpuRs = r[16];
			cpuWrN = r[17];
			cpuRdN = r[18];
			cpuCsN = r[19];
			cpuResetN = r[20];
			#1;
			assert (screenD == cpuD && screenRs == cpuRs && screenWrN == cpuWrN
				&& screenRdN == cpuRdN && screenCsN == cpuCsN && screenResetN == cpuResetN)
			else
			begin
				$display("Mismatch at %0t: passthrough screen %h %b%b%b%b%b, cpu %h %b%b%b%b%b",
					$time, screenD, screenRs, screenWrN, screenRdN, screenCsN, screenResetN,
					cpuD, cpuRs, cpuWrN, cpuRdN, cpuCsN, cpuResetN);
				errorCount++;
			end
		end
		@(negedge clk);
		driveIdle();
	endtask

	// sprites move once at every frame start, before the first pixel
	task automatic startFrame();
		modelCharX = clampStep(modelCharX, vecCharVx[curVec], limitX);
		modelCharY = clampStep(modelCharY, vecCharVy[curVec], limitY);
		modelCoinX = wrapStep(modelCoinX, vecCoinVx[curVec], limitX);
		modelCoinY = wrapStep(modelCoinY, vecCoinVy[curVec], limitY);
		bothSeen = 0;
		charSeen = 0;
		coinSeen = 0;
		blankSeen = 0;
	endtask

	task automatic endFrame();
		int charArea;
		int coinArea;
		int bothArea;
		charArea = overlapLen(modelCharX, modelCharX, panelWidth)
			* overlapLen(modelCharY, modelCharY, panelHeight);
		coinArea = overlapLen(modelCoinX, modelCoinX, panelWidth)
			* overlapLen(modelCoinY, modelCoinY, panelHeight);
		bothArea = overlapLen(modelCharX, modelCoinX, panelWidth)
			* overlapLen(modelCharY, modelCoinY, panelHeight);
		assert (bothSeen == bothArea && charSeen == charArea - bothArea
			&& coinSeen == coinArea - bothArea
			&& blankSeen == framePixels - charArea - coinArea + bothArea)
		else
		begin
			$display("Mismatch at %0t: frame %0d colors %0d/%0d/%0d/%0d, want %0d/%0d/%0d/%0d",
				$time, frameCount, bothSeen, charSeen, coinSeen, blankSeen, bothArea,
				charArea - bothArea, coinArea - bothArea,
				framePixels - charArea - coinArea + bothArea);
			errorCount++;
		end
		assert (int'(charX) == modelCharX && int'(charY) == modelCharY)
		else
		begin
			$display("Mismatch at %0t: frame %0d character at %0d,%0d, expected %0d,%0d",
				$time, frameCount, charX, charY, modelCharX, modelCharY);
			errorCount++;
		end
		frameCount++;
	endtask

	// one latched word, cursor home first, then the pixels row by row
	task automatic takeWord(input lcdPkg::lcdWordT data, input logic rs);
		logic known;
		logic [6:0] homeRs;
		homeRs = 7'b0110110;
		if (wordIndex == 0)
			startFrame();
		if (wordIndex < homeWords)
		begin
			assert (data == homeWord(wordIndex) && rs == homeRs[6 - wordIndex])
			else
			begin
				$display("Mismatch at %0t: home word %0d is %h rs %b, expected %h rs %b", $time,
					wordIndex, data, rs, homeWord(wordIndex), homeRs[6 - wordIndex]);
				errorCount++;
			end
		end
		else
		begin
			known = (data == lcdPkg::colorBoth) || (data == lcdPkg::colorChar)
				|| (data == lcdPkg::colorCoin) || (data == lcdPkg::colorBlank);
			assert (rs == 1'b1 && known)
			else
			begin
				$display("Mismatch at %0t: pixel %0d word %h rs %b, expected a color, rs 1",
					$time, wordIndex - homeWords, data, rs);
				errorCount++;
			end
			if (data == lcdPkg::colorBoth)
				bothSeen++;
			else if (data == lcdPkg::colorChar)
				charSeen++;
			else if (data == lcdPkg::colorCoin)
				coinSeen++;
			else if (data == lcdPkg::colorBlank)
				blankSeen++;
		end
		wordIndex++;
		if (wordIndex == homeWords + framePixels)
		begin
			endFrame();
			wordIndex = 0;
		end
	endtask

	// panel latches on the rising edge of the write strobe
	// chip select follows the write strobe on every engine word
	always @(negedge clk)
	begin
		if (monitorOn)
		begin
			assert (screenCsN == screenWrN)
			else
			begin
				$display("Mismatch at %0t: chip select %b, write strobe %b", $time,
					screenCsN, screenWrN);
				errorCount++;
			end
		end
		if (monitorOn && !lastWrN && screenWrN)
			takeWord(screenD, screenRs);
		lastWrN = screenWrN;
	end

	task automatic runVector(input int k);
		int errorsBefore;
		int target;
		errorsBefore = errorCount;
		curVec = k;
		@(negedge clk);
		charVx = vecCharVx[k][10:0];
		charVy = vecCharVy[k][10:0];
		coinVx = vecCoinVx[k][10:0];
		coinVy = vecCoinVy[k][10:0];
		// coin origin loads while the CPU still holds the panel
		coinX0 = vecCoinX0[k][10:0];
		coinY0 = vecCoinY0[k][10:0];
		modelCoinX = vecCoinX0[k];
		modelCoinY = vecCoinY0[k];
		writeCommand(1'b1);
		wordIndex = 0;
		@(negedge clk);
		monitorOn = 1'b1;
		target = frameCount + vecFrames[k];
		wait (frameCount == target);
		monitorOn = 1'b0;
		assert (finish == vecFinish[k][0])
		else
		begin
			$display("Mismatch at %0t: vector %0d finish %b, expected %0d",
				$time, k, finish, vecFinish[k]);
			errorCount++;
		end
		// next frame has begun before the release, so the character stepped once more
		modelCharX = clampStep(modelCharX, vecCharVx[k], limitX);
		modelCharY = clampStep(modelCharY, vecCharVy[k], limitY);
		writeCommand(1'b0);
		@(negedge clk);
		assert (finish == 1'b0 && int'(charX) == modelCharX && int'(charY) == modelCharY)
		else
		begin
			$display("Mismatch at %0t: released finish %b char %0d,%0d, expected 0 %0d,%0d",
				$time, finish, charX, charY, modelCharX, modelCharY);
			errorCount++;
		end
		checkPassthrough(20);
		testsRun++;
		if (errorCount != errorsBefore)
			testsFailed++;
		$display("vector %0d: %0d frames, finish %0d, %s", k, vecFrames[k], vecFinish[k],
			(errorCount == errorsBefore) ? "ok" : "failed");
	endtask

	// decimal columns, lines that do not scan as eight numbers are skipped
	task automatic readVectors(output logic loaded);
		int fd;
		int fields;
		int v [8];
		string lineText;
		loaded = 1'b0;
		vecCount = 0;
		fd = $fopen("dv/lcdVectors.txt", "r");
		if (fd != 0)
		begin
			while ($fgets(lineText, fd) != 0)
			begin
				fields = $sscanf(lineText, "%d %d %d %d %d %d %d %d",
					v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7]);
				if (fields == 8 && vecCount < maxVectors)
				begin
					vecCoinX0[vecCount] = v[0];
					vecCoinY0[vecCount] = v[1];
					vecCoinVx[vecCount] = v[2];
					vecCoinVy[vecCount] = v[3];
					vecCharVx[vecCount] = v[4];
					vecCharVy[vecCount] = v[5];
					vecFrames[vecCount] = v[6];
					vecFinish[vecCount] = v[7];
					timeoutLimit = timeoutLimit + longint'(v[6]) * frameCycles;
					vecCount++;
				end
			end
			$fclose(fd);
			loaded = (vecCount > 0);
		end
	endtask

	always @(posedge clk)
	begin
		cycleCount = cycleCount + 1;
		if (cycleCount >= timeoutLimit)
		begin
			$display("Timeout after %0d cycles, the engine did not finish its frames", cycleCount);
			$display("Simulation finished: FAIL");
			$finish;
		end
	end

	initial
	begin
		logic loaded;
		int errorsBefore;
		rst = 1'b1;
		bufferRequest = 1'b0;
		charVx = '0;
		charVy = '0;
		coinX0 = '0;
		coinY0 = '0;
		coinVx = '0;
		coinVy = '0;
		driveIdle();
		readVectors(loaded);
		if (!loaded)
		begin
			$display("Could not read any vector from dv/lcdVectors.txt");
			$display("Simulation finished: FAIL");
			$finish;
		end
		else
		begin
			repeat (5) @(posedge clk);
			@(negedge clk);
			rst = 1'b0;
			errorsBefore = errorCount;
			checkPassthrough(200);
			testsRun++;
			if (errorCount != errorsBefore)
				testsFailed++;
			$display("passthrough: 200 bus values, %s",
				(errorCount == errorsBefore) ? "ok" : "failed");
			for (int k = 0; k < vecCount; k++)
				runVector(k);
			$display("%0d tests run, %0d failed, %0d check errors",
				testsRun, testsFailed, errorCount);
			if (errorCount == 0)
				$display("Simulation finished: PASS");
			else
				$display("Simulation finished: FAIL");
			$finish;
		end
	end

endmodule

`default_nettype wire

// File: dv/lcdVectors.txt
# coinX0 coinY0 coinVx coinVy charVx charVy frames finish
# decimal, velocities signed, finish is 1 when the sprites overlap in any frame
150 200 2 3 5 4 2 0
30 30 1 -1 0 0 1 1
5 5 -10 -8 100 150 3 1
100 100 30 25 -250 -5 2 0
210 290 15 15 8 -130 2 1

// File: lcdFrameEngine.f
common/lcdPkg.sv
common/scanStepIf.sv
common/lcdWriteIf.sv
frameWriter/frameSequencer.sv
frameWriter/spriteRenderer.sv
game/spriteMotion.sv
src/busArbiter.sv
src/lcdFrameEngine.sv
dv/lcdFrameEngineTb.sv

// File: runSim.sh
#!/bin/sh
# build and run the frame engine testbench with Verilator, result read from sim.log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --assert -Wno-fatal --top-module lcdFrameEngineTb \
	-f lcdFrameEngine.f -o simv > sim.log 2>&1 &&
	./obj_dir/simv >> sim.log 2>&1 ||
	echo "build or simulation exited with an error" >> sim.log
grep -q "Simulation finished: FAIL" sim.log && { echo "simulation failed, see sim.log"; exit 1; }
grep -q "Simulation finished: PASS" sim.log || { echo "no result in sim.log"; exit 1; }
echo "simulation passed"
